// File: verif/mul_tests.txt
# op op1 op2 expected stall   (op: 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU; op1 op2 expected in hex)
# stall: extra cycles rsp_ready stays low after rsp_valid is seen (decimal)
0 00000000 00000000 00000000 0
1 00000000 ffffffff 00000000 1
0 00000001 00000001 00000001 0
3 00000001 ffffffff 00000000 2
0 ffffffff ffffffff 00000001 0
1 ffffffff ffffffff 00000000 3
3 ffffffff ffffffff fffffffe 1
2 ffffffff ffffffff ffffffff 0
0 80000000 80000000 00000000 0
1 80000000 80000000 40000000 5
2 80000000 80000000 c0000000 0
3 80000000 80000000 40000000 2
0 80000000 ffffffff 80000000 1
1 80000000 ffffffff 00000000 0
2 80000000 ffffffff 80000000 4
3 80000000 ffffffff 7fffffff 0
2 00000002 ffffffff 00000001 0
2 ffffffff 00000001 ffffffff 1
2 7fffffff 80000000 3fffffff 0
2 00000001 80000000 00000000 2
1 7fffffff 7fffffff 3fffffff 0
0 7fffffff 7fffffff 00000001 3
1 80000000 00000001 ffffffff 0
1 00000003 fffffffd ffffffff 0
0 00000003 fffffffd fffffff7 1
0 12345678 00000010 23456780 0
3 00010000 00010000 00000001 0
0 0000ffff 0000ffff fffe0001 2

// File: sim.f
+incdir+rtl
rtl/mul_pkg.sv
rtl/mul_ctrl.sv
rtl/booth_recoder.sv
rtl/pp_select.sv
rtl/bk_adder.sv
rtl/mul_accum.sv
rtl/mul_unit.sv
verif/tb_mul_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the multiply unit testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_mul_unit -f sim.f > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtb_mul_unit > sim.log 2>&1 \
  || { echo "Simulation exited abnormally, see sim.log"; exit 1; }

grep -q "Done: errors found" sim.log && { echo "FAIL, see sim.log"; exit 1; } \
  || { echo "PASS"; exit 0; }

// File: verif/tb_mul_unit.sv
`include "mul_settings.svh"

module tb_mul_unit import mul_pkg::*; ();

  localparam int N_RANDOM = 40;

  logic     clk;
  logic     rst_n;
  logic     req_valid;
  mul_req_t req;
  logic     req_ready;
  logic     rsp_valid;
  mul_rsp_t rsp;
  logic     rsp_ready;

  // Test list, directed vectors from the file first, random ones after
  mul_op_e              q_op[$];
  logic [`MUL_XLEN-1:0] q_op1[$];
  logic [`MUL_XLEN-1:0] q_op2[$];
  mul_rsp_t             q_exp[$];
  int                   q_stall[$];

  logic [31:0] rng_state;
  int          value_errors = 0;
  int          other_errors = 0;
  int          cycles = 0;
  int          cycle_limit = 0;

  mul_unit u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .rsp_ready (rsp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Run limit, set once the test list is known
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("TIMEOUT: test list not finished after %0d cycles", cycles);
      $display("Summary: %0d value errors, %0d other errors, run stopped by timeout",
               value_errors, other_errors);
      $display("Done: errors found");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Full product from the op definitions, then pick a half
  function automatic mul_rsp_t expected_rsp(input mul_op_e op, input logic [`MUL_XLEN-1:0] a,
                                            input logic [`MUL_XLEN-1:0] b);
    logic [`MUL_PLEN-1:0] a_ext;
    logic [`MUL_PLEN-1:0] b_ext;
    logic [`MUL_PLEN-1:0] prod;
    mul_rsp_t             r;
    a_ext = {{`MUL_XLEN{1'b0}}, a};
    b_ext = {{`MUL_XLEN{1'b0}}, b};
    // Signed multiplicand for MULH and MULHSU, signed multiplier for MULH
    if (op == OP_MULH || op == OP_MULHSU) a_ext = {{`MUL_XLEN{a[`MUL_XLEN-1]}}, a};
    if (op == OP_MULH) b_ext = {{`MUL_XLEN{b[`MUL_XLEN-1]}}, b};
    prod = a_ext * b_ext;
    r.res = (op == OP_MUL) ? prod[`MUL_XLEN-1:0] : prod[`MUL_PLEN-1:`MUL_XLEN];
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_rsp(input string name, input mul_rsp_t exp, input mul_rsp_t act);
    if (act !== exp) begin
      value_errors++;
      $display("CHECK FAILED at time %0t: %s expected %h, got %h", $time, name, exp.res,
               act.res);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("CHECK FAILED at time %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic report_error(input string what);
    other_errors++;
    $display("ERROR at time %0t: %s", $time, what);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test list
  //////////////////////////////////////////////////////////////////////

  task automatic load_tests();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [31:0] f_exp;
    int          f_stall;
    mul_rsp_t    e;
    fd = $fopen("verif/mul_tests.txt", "r");
    if (fd == 0) begin
      report_error("the directed test file verif/mul_tests.txt could not be opened");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      // Lines starting with # are column notes
      if ($fgets(line, fd) > 0 && line.len() > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %d", f_op, f_a, f_b, f_exp, f_stall);
        if (n == 5) begin
          e.res = f_exp;
          q_op.push_back(mul_op_e'(f_op[1:0]));
          q_op1.push_back(f_a);
          q_op2.push_back(f_b);
          q_exp.push_back(e);
          q_stall.push_back(f_stall);
        end
      end
    end
    $fclose(fd);
    if (q_op.size() == 0) report_error("no directed vectors were read from the test file");
  endtask

  task automatic add_random_tests(input int count);
    int          i;
    logic [31:0] r;
    mul_op_e     op;
    logic [31:0] a;
    logic [31:0] b;
    for (i = 0; i < count; i++) begin
      r  = next_random();
      op = mul_op_e'(r[1:0]);
      a  = next_random();
      b  = next_random();
      r  = next_random();
      q_op.push_back(op);
      q_op1.push_back(a);
      q_op2.push_back(b);
      q_exp.push_back(expected_rsp(op, a, b));
      // Short back-pressure, 0 to 3 extra cycles
      q_stall.push_back(int'(r & 32'h3));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // One request from presentation to response transfer
  //////////////////////////////////////////////////////////////////////

  task automatic run_request(input mul_op_e op, input logic [`MUL_XLEN-1:0] a,
                             input logic [`MUL_XLEN-1:0] b, input mul_rsp_t exp,
                             input int stall);
    int edges;
    int s;
    bit seen;
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= '{op: op, op1: a, op2: b};
    rsp_ready <= 1'b0;
    edges = 0;
    @(negedge clk);
    while (!req_ready && edges < 4) begin
      @(negedge clk);
      edges++;
    end
    if (!req_ready) report_error("req_ready stayed low while the unit should be idle");
    // Accept edge, then keep valid high with other operands while busy
    @(posedge clk);
    req <= '{op: mul_op_e'(~op), op1: ~a, op2: b ^ 32'h5a5a_5a5a};
    edges = 0;
    seen  = 1'b0;
    // Each busy cycle without rsp_valid is one more edge after accept
    while (!seen && edges < `MUL_STEPS + 8) begin
      @(negedge clk);
      check_bit("req_ready", 1'b0, req_ready);
      if (rsp_valid) seen = 1'b1;
      else edges++;
    end
    if (!seen) begin
      report_error($sformatf("rsp_valid never rose within %0d edges of accept", edges));
    end else if (edges != `MUL_STEPS) begin
      report_error($sformatf("rsp_valid rose %0d edges after accept instead of %0d",
                             edges, `MUL_STEPS));
    end
    check_rsp("rsp", exp, rsp);
    // Back-pressure, response must hold
    for (s = 0; s < stall; s++) begin
      @(posedge clk);
      @(negedge clk);
      check_bit("rsp_valid", 1'b1, rsp_valid);
      check_bit("req_ready", 1'b0, req_ready);
      check_rsp("rsp", exp, rsp);
    end
    @(posedge clk);
    rsp_ready <= 1'b1;
    @(negedge clk);
    check_bit("rsp_valid", 1'b1, rsp_valid);
    check_rsp("rsp", exp, rsp);
    // Transfer edge
    @(posedge clk);
    rsp_ready <= 1'b0;
    req_valid <= 1'b0;
    @(negedge clk);
    check_bit("req_ready", 1'b1, req_ready);
    check_bit("rsp_valid", 1'b0, rsp_valid);
  endtask

  initial begin
    int max_stall;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    rng_state = 32'hf70e5b3c;
    load_tests();
    add_random_tests(N_RANDOM);
    max_stall = 0;
    foreach (q_stall[i]) begin
      if (q_stall[i] > max_stall) max_stall = q_stall[i];
    end
    cycle_limit = q_op.size() * (`MUL_STEPS + max_stall + 4) + 100;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    // Idle state straight after reset
    @(negedge clk);
    check_bit("req_ready", 1'b1, req_ready);
    check_bit("rsp_valid", 1'b0, rsp_valid);
    foreach (q_op[i]) begin
      run_request(q_op[i], q_op1[i], q_op2[i], q_exp[i], q_stall[i]);
    end
    $display("Summary: %0d requests, %0d value errors, %0d other errors", q_op.size(),
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: rtl/mul_unit.sv
`include "mul_settings.svh"

module mul_unit import mul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_valid,
  input  mul_req_t req,
  output logic     req_ready,
  output logic     rsp_valid,
  output mul_rsp_t rsp,
  input  logic     rsp_ready
);

  logic                 load;
  logic                 step;
  booth_sel_t           sel;
  logic [`MUL_PLEN-1:0] pp;
  logic                 cin;
  logic [`MUL_PLEN-1:0] acc_shl;
  logic [`MUL_PLEN-1:0] sum;
  logic [`MUL_XLEN-1:0] res;

  // Handshake and step sequencing
  mul_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .rsp_ready (rsp_ready),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .load      (load),
    .step      (step)
  );

  // Multiplier digits
  booth_recoder u_recoder (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (load),
    .step  (step),
    .op2   (req.op2),
    .op    (req.op),
    .sel   (sel)
  );

  // Multiplicand times digit
  pp_select u_pp (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (load),
    .op1   (req.op1),
    .op    (req.op),
    .sel   (sel),
    .pp    (pp),
    .cin   (cin)
  );

  bk_adder #(
    .WIDTH (`MUL_PLEN)
  ) u_adder (
    .a   (acc_shl),
    .b   (pp),
    .cin (cin),
    .sum (sum)
  );

  mul_accum u_accum (
    .clk     (clk),
    .rst_n   (rst_n),
    .load    (load),
    .step    (step),
    .op      (req.op),
    .sum     (sum),
    .acc_shl (acc_shl),
    .res     (res)
  );

  assign rsp = '{res: res};

endmodule

// File: rtl/mul_accum.sv
`include "mul_settings.svh"

module mul_accum import mul_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load,
  input  logic                 step,
  input  mul_op_e              op,
  input  logic [`MUL_PLEN-1:0] sum,
  output logic [`MUL_PLEN-1:0] acc_shl,
  output logic [`MUL_XLEN-1:0] res
);

  logic [`MUL_PLEN-1:0] acc;
  logic                 hi_sel;

  //////////////////////////////////////////////////////////////////////
  // Accumulator
  //////////////////////////////////////////////////////////////////////

  // Cleared at accept, updated once per digit, held in SEND
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc    <= '0;
      hi_sel <= 1'b0;
    end else if (load) begin
      acc    <= '0;
      hi_sel <= op_is_high(op);
    end else if (step) begin
      acc    <= sum;
    end
  end

  // Earlier digits weigh four times more than the next one
  assign acc_shl = {acc[`MUL_PLEN-3:0], 2'b00};

  // Half select for the response
  assign res = hi_sel ? acc[`MUL_PLEN-1:`MUL_XLEN] : acc[`MUL_XLEN-1:0];

endmodule

// File: rtl/bk_adder.sv
`include "mul_settings.svh"

module bk_adder #(
  parameter int WIDTH = `MUL_PLEN
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic             cin,
  output logic [WIDTH-1:0] sum
);

  localparam int LVL = $clog2(WIDTH);

  // Group generate/propagate per up-sweep level
  logic [LVL:0][WIDTH-1:0]   gu;
  logic [LVL:0][WIDTH-1:0]   pu;
  // Group generate per down-sweep level
  logic [LVL-1:0][WIDTH-1:0] gd;
  logic [WIDTH-1:0]          carry;

  //////////////////////////////////////////////////////////////////////
  // Bit level generate/propagate
  //////////////////////////////////////////////////////////////////////

  // Carry in folded into bit 0 so prefixes carry it along
  assign gu[0] = (a & b) | {{(WIDTH-1){1'b0}}, (a[0] ^ b[0]) & cin};
  assign pu[0] = a ^ b;

  //////////////////////////////////////////////////////////////////////
  // Up-sweep, spans double each level
  //////////////////////////////////////////////////////////////////////

  for (genvar l = 1; l <= LVL; l++) begin : g_up
    localparam int D = 1 << (l - 1);
    for (genvar i = 0; i < WIDTH; i++) begin : g_bit
      if (((i + 1) % (2 * D)) == 0) begin : g_cell
        assign gu[l][i] = gu[l-1][i] | (pu[l-1][i] & gu[l-1][i-D]);
        assign pu[l][i] = pu[l-1][i] & pu[l-1][i-D];
      end else begin : g_pass
        assign gu[l][i] = gu[l-1][i];
        assign pu[l][i] = pu[l-1][i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Down-sweep fills in the remaining prefixes
  //////////////////////////////////////////////////////////////////////

  assign gd[0] = gu[LVL];

  for (genvar d = 1; d < LVL; d++) begin : g_dn
    localparam int D = 1 << (LVL - 1 - d);
    for (genvar i = 0; i < WIDTH; i++) begin : g_bit
      // Node sits half a span above a finished prefix
      if ((((i + 1) % (2 * D)) == D) && (i >= 2 * D)) begin : g_cell
        assign gd[d][i] = gd[d-1][i] | (pu[LVL][i] & gd[d-1][i-D]);
      end else begin : g_pass
        assign gd[d][i] = gd[d-1][i];
      end
    end
  end

  // Carry into bit i is the prefix generate of bits below it
  assign carry = {gd[LVL-1][WIDTH-2:0], cin};
  assign sum   = pu[0] ^ carry;

endmodule

// File: rtl/pp_select.sv
`include "mul_settings.svh"

module pp_select import mul_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load,
  input  logic [`MUL_XLEN-1:0] op1,
  input  mul_op_e              op,
  input  booth_sel_t           sel,
  output logic [`MUL_PLEN-1:0] pp,
  output logic                 cin
);

  logic [`MUL_PLEN-1:0] mcand;
  logic [`MUL_PLEN-1:0] mag;
  logic                 ext;

  //////////////////////////////////////////////////////////////////////
  // Multiplicand register
  //////////////////////////////////////////////////////////////////////

  // Sign bit only for ops with a signed multiplicand
  assign ext = op1_is_signed(op) & op1[`MUL_XLEN-1];

  // Held for the whole calculation
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) mcand <= '0;
    else if (load) mcand <= {{`MUL_XLEN{ext}}, op1};
  end

  //////////////////////////////////////////////////////////////////////
  // Partial product
  //////////////////////////////////////////////////////////////////////

  // Magnitude is 0, 1x or 2x
  always_comb begin
    if (sel.zero) mag = '0;
    else if (sel.two) mag = {mcand[`MUL_PLEN-2:0], 1'b0};
    else mag = mcand;
  end

  // Negative digit as invert plus one, the one enters as adder carry
  // All-ones plus one also wraps to zero if zero and neg ever meet
  assign pp  = sel.neg ? ~mag : mag;
  assign cin = sel.neg;

endmodule

// File: rtl/booth_recoder.sv
`include "mul_settings.svh"

module booth_recoder import mul_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load,
  input  logic                 step,
  input  logic [`MUL_XLEN-1:0] op2,
  input  mul_op_e              op,
  output booth_sel_t           sel
);

  // Two sign bits, the operand, and the implicit zero below bit 0
  localparam int RW = `MUL_XLEN + 3;

  logic [RW-1:0] mplr;
  logic          ext;
  logic [2:0]    digit;

  // Zero extension for unsigned multipliers
  assign ext = op2_is_signed(op) & op2[`MUL_XLEN-1];

  // Most significant digit first, shift two bits per step
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) mplr <= '0;
    else if (load) mplr <= {ext, ext, op2, 1'b0};
    else if (step) mplr <= {mplr[RW-3:0], 2'b00};
  end

  assign digit = mplr[RW-1:RW-3];

  // Radix-4 Booth table
  always_comb begin
    sel = '{zero: 1'b0, two: 1'b0, neg: 1'b0};
    case (digit)
      3'b000, 3'b111: sel.zero = 1'b1;
      3'b001, 3'b010: ;                                   // +1x
      3'b011: sel.two = 1'b1;                             // +2x
      3'b100: sel = '{zero: 1'b0, two: 1'b1, neg: 1'b1};  // -2x
      3'b101, 3'b110: sel.neg = 1'b1;                     // -1x
      default: sel.zero = 1'b1;
    endcase
  end

endmodule

// File: rtl/mul_ctrl.sv
`include "mul_settings.svh"

module mul_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic req_valid,
  input  logic rsp_ready,
  output logic req_ready,
  output logic rsp_valid,
  output logic load,
  output logic step
);

  localparam int CNT_W = $clog2(`MUL_STEPS);

  typedef enum logic [1:0] {
    S_IDLE,
    S_CALC,
    S_SEND
  } state_e;

  state_e state;
  state_e state_nxt;
  logic [CNT_W-1:0] cnt;
  logic last_step;

  //////////////////////////////////////////////////////////////////////
  // Handshake and datapath strobes
  //////////////////////////////////////////////////////////////////////

  // Only one item in flight, so ready just means idle
  assign req_ready = (state == S_IDLE);
  assign rsp_valid = (state == S_SEND);
  // Operands are captured on the accept edge
  assign load      = req_valid && req_ready;
  // One Booth digit retired per CALC cycle
  assign step      = (state == S_CALC);
  assign last_step = (cnt == CNT_W'(`MUL_STEPS - 1));

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE: if (load) state_nxt = S_CALC;
      S_CALC: if (last_step) state_nxt = S_SEND;
      // Wait here under back-pressure
      S_SEND: if (rsp_ready) state_nxt = S_IDLE;
      default: state_nxt = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      // Counter wraps on the last digit, ready for the next request
      if (step) cnt <= last_step ? '0 : cnt + 1'b1;
    end
  end

endmodule

// File: rtl/mul_pkg.sv
`include "mul_settings.svh"

package mul_pkg;

  // Operation codes, same order as the RISC-V funct3 field
  typedef enum logic [1:0] {
    OP_MUL    = 2'b00,
    OP_MULH   = 2'b01,
    OP_MULHSU = 2'b10,
    OP_MULHU  = 2'b11
  } mul_op_e;

  // One request, 66 bits
  typedef struct packed {
    mul_op_e              op;
    logic [`MUL_XLEN-1:0] op1;   // multiplicand
    logic [`MUL_XLEN-1:0] op2;   // multiplier
  } mul_req_t;

  // One response
  typedef struct packed {
    logic [`MUL_XLEN-1:0] res;
  } mul_rsp_t;

  // Decoded action of a single Booth digit
  typedef struct packed {
    logic zero;   // add nothing
    logic two;    // use the doubled multiplicand
    logic neg;    // subtract instead of add
  } booth_sel_t;

  // Multiplicand is signed for MULH and MULHSU
  function automatic logic op1_is_signed(mul_op_e op);
    return (op == OP_MULH) || (op == OP_MULHSU);
  endfunction

  // Multiplier is signed for MULH only
  function automatic logic op2_is_signed(mul_op_e op);
    return (op == OP_MULH);
  endfunction

  // Every op except MUL returns the upper half
  function automatic logic op_is_high(mul_op_e op);
    return (op != OP_MUL);
  endfunction

endpackage

// File: rtl/mul_settings.svh
`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

// Operand width in bits
// Must stay a power of two for the prefix adder
`define MUL_XLEN 32

// Full product width
`define MUL_PLEN (2 * `MUL_XLEN)

// Radix-4 digits per operand plus one for the zero-extended unsigned case
`define MUL_STEPS (`MUL_XLEN / 2 + 1)

`endif
